// File: logic/div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// Operand widths
`define DIV_N_W 16
`define DIV_D_W 8

// Lowest quotient rows built from approximate cells in approximate mode
`define DIV_APPROX_ROWS 4

`endif

// File: logic/div_pkg.sv
`include "div_params.svh"

package div_pkg;

  typedef logic [`DIV_N_W-1:0] dividend_t;
  typedef logic [`DIV_D_W-1:0] divisor_t;
  typedef logic [`DIV_D_W-1:0] quot_t;
  typedef logic [`DIV_D_W-1:0] rem_t;

  typedef enum logic [1:0] {
    fault_none     = 2'd0,
    fault_div_zero = 2'd1,
    fault_overflow = 2'd2
  } fault_e;

  typedef enum logic [1:0] {
    st_ok       = 2'd0,
    st_div_zero = 2'd1,
    st_overflow = 2'd2
  } status_e;

  typedef enum logic [1:0] {
    hs_idle    = 2'd0,
    hs_busy    = 2'd1,
    hs_release = 2'd2
  } hs_state_e;

  typedef struct packed {
    dividend_t dividend;
    divisor_t  divisor;
    logic      approx;   // 1 selects approximate cells
  } div_req_t;

  typedef struct packed {
    div_req_t op;
    fault_e   fault;
  } div_dec_t;

  typedef struct packed {
    rem_t   n_lo;        // Dividend low byte for the divide by zero remainder
    quot_t  q;
    rem_t   r;
    fault_e fault;
  } div_exe_t;

  typedef struct packed {
    quot_t   q;
    rem_t    r;
    status_e status;
  } div_resp_t;

endpackage

// File: logic/div_cell.sv
module div_cell (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  input  logic approx,
  output logic diff_out,
  output logic bout
);

  logic diff_exact;
  logic bout_exact;
  logic diff_apx;
  logic bout_apx;

  assign diff_exact = x ^ y ^ bin;
  assign bout_exact = (~x & y) | (~(x ^ y) & bin);

  // Borrow ignores x and bin
  assign bout_apx = ~y;
  assign diff_apx = (~x & y & ~bin) | (x & ~y) | (x & y & bin);

  assign bout     = approx ? bout_apx : bout_exact;
  assign diff_out = qs ? (approx ? diff_apx : diff_exact) : x;  // Restore when qs is 0

endmodule

// File: logic/div_array.sv
`include "div_params.svh"

module div_array #(
  parameter int approx_rows = `DIV_APPROX_ROWS
) (
  input  div_pkg::dividend_t n,
  input  div_pkg::divisor_t  d,
  input  logic               approx,
  output div_pkg::quot_t     q,
  output div_pkg::rem_t      r
);

  localparam int dw = `DIV_D_W;

  // Partial remainder and borrow per quotient row, indexed [row][bit]
  logic [dw-1:0] r_loc [dw];
  logic [dw-1:0] b_loc [dw];

  for (genvar i = 0; i < dw; i++) begin : g_row
    logic row_approx;

    assign row_approx = (i < approx_rows) ? approx : 1'b0;

    for (genvar j = 0; j < dw; j++) begin : g_col
      logic x_in;
      logic bin_in;

      if (j == 0) begin : g_lsb
        assign x_in   = n[i];          // Next dividend bit enters at the LSB
        assign bin_in = 1'b0;
      end else if (i == dw - 1) begin : g_top
        assign x_in   = n[dw-1+j];     // Top row works on the dividend directly
        assign bin_in = b_loc[i][j-1];
      end else begin : g_mid
        assign x_in   = r_loc[i+1][j-1];
        assign bin_in = b_loc[i][j-1];
      end

      div_cell u_cell (
        .x        (x_in),
        .y        (d[j]),
        .bin      (bin_in),
        .qs       (q[i]),
        .approx   (row_approx),
        .diff_out (r_loc[i][j]),
        .bout     (b_loc[i][j])
      );
    end

    // Quotient bit set by a carried-out high bit or no final borrow
    if (i == dw - 1) begin : g_q_top
      assign q[i] = n[`DIV_N_W-1] | ~b_loc[i][dw-1];
    end else begin : g_q_mid
      assign q[i] = r_loc[i+1][dw-1] | ~b_loc[i][dw-1];
    end
  end

  assign r = r_loc[0];

endmodule

// File: logic/div_decode.sv
`include "div_params.svh"

module div_decode (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req,
  input  div_pkg::div_req_t req_data,
  input  logic              done,
  output logic              ack,
  output logic              issue,
  output div_pkg::div_dec_t dec
);

  import div_pkg::*;

  hs_state_e state;
  fault_e    fault;
  divisor_t  n_hi;
  logic      start;

  assign n_hi  = req_data.dividend[`DIV_N_W-1 -: `DIV_D_W];
  assign start = (state == hs_idle) && req;

  // Divide by zero has priority over overflow
  always_comb begin
    if (req_data.divisor == '0) begin
      fault = fault_div_zero;
    end else if (n_hi >= req_data.divisor) begin
      fault = fault_overflow;  // Quotient would not fit in 8 bits
    end else begin
      fault = fault_none;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= hs_idle;
      ack   <= 1'b0;
      issue <= 1'b0;
    end else begin
      issue <= start;
      case (state)
        hs_idle: begin
          if (req) state <= hs_busy;
        end
        hs_busy: begin
          if (done) begin
            ack   <= 1'b1;
            state <= hs_release;
          end
        end
        hs_release: begin
          // Wait for the requester to drop req
          if (!req) begin
            ack   <= 1'b0;
            state <= hs_idle;
          end
        end
        default: state <= hs_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dec.op    <= req_data;
      dec.fault <= fault;
    end
  end

endmodule

// File: logic/div_execute.sv
module div_execute (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue,
  input  div_pkg::div_dec_t dec,
  output logic              exe_valid,
  output div_pkg::div_exe_t exe
);

  import div_pkg::*;

  quot_t q;
  rem_t  r;

  // Operands stay stable in dec until the next capture
  div_array u_array (
    .n      (dec.op.dividend),
    .d      (dec.op.divisor),
    .approx (dec.op.approx),
    .q      (q),
    .r      (r)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      exe.n_lo  <= rem_t'(dec.op.dividend);  // Low byte
      exe.q     <= q;
      exe.r     <= r;
      exe.fault <= dec.fault;
    end
  end

endmodule

// File: logic/div_result.sv
module div_result (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               exe_valid,
  input  div_pkg::div_exe_t  exe,
  output logic               done,
  output div_pkg::div_resp_t resp
);

  import div_pkg::*;

  div_resp_t resp_next;

  function automatic status_e to_status(fault_e f);
    status_e s;
    case (f)
      fault_div_zero: s = st_div_zero;
      fault_overflow: s = st_overflow;
      default:        s = st_ok;
    endcase
    return s;
  endfunction

  always_comb begin
    resp_next.q      = exe.q;
    resp_next.r      = exe.r;
    resp_next.status = to_status(exe.fault);
    case (exe.fault)
      fault_div_zero: begin
        resp_next.q = '1;
        resp_next.r = exe.n_lo;  // Dividend passes through as remainder
      end
      fault_overflow: begin
        resp_next.q = '1;
        resp_next.r = '1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else begin
      done <= exe_valid;
    end
  end

  // Held until the next result so ack can present it
  always_ff @(posedge clk) begin
    if (exe_valid) begin
      resp <= resp_next;
    end
  end

endmodule

// File: logic/approx_div_unit.sv
module approx_div_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               req,
  input  div_pkg::div_req_t  req_data,
  output logic               ack,
  output div_pkg::div_resp_t resp
);

  import div_pkg::*;

  logic     issue;
  logic     exe_valid;
  logic     done;
  div_dec_t dec;
  div_exe_t exe;

  div_decode u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .req_data (req_data),
    .done     (done),
    .ack      (ack),
    .issue    (issue),
    .dec      (dec)
  );

  div_execute u_execute (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .dec       (dec),
    .exe_valid (exe_valid),
    .exe       (exe)
  );

  div_result u_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .exe_valid (exe_valid),
    .exe       (exe),
    .done      (done),
    .resp      (resp)
  );

endmodule

// File: dv/approx_div_unit_asserts.sv
module approx_div_unit_asserts (
  input logic               clk,
  input logic               arst_n,
  input logic               req,
  input logic               ack,
  input div_pkg::hs_state_e state
);
  timeunit 1ns;
  timeprecision 1ps;

  import div_pkg::*;

  logic capture;

  assign capture = (state == hs_idle) && req;  // Edge that takes a new request

  ack_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !ack)
    else $error("ack high when reset was released");

  // ack only answers a request that is still pending
  ack_needs_req: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(ack) |-> $past(req)
  ) else $error("ack rose without a pending req");

  ack_latency: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(ack) |-> $past(capture, 4)
  ) else $error("ack did not rise on the fourth edge after the capture edge");

endmodule

bind div_decode approx_div_unit_asserts i_hs_asserts (
  .clk    (clk),
  .arst_n (arst_n),
  .req    (req),
  .ack    (ack),
  .state  (state)
);

// File: dv/approx_div_unit_tb.sv
module approx_div_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import div_pkg::*;

  localparam int max_tests     = 32;
  localparam int reset_cycles  = 8;
  localparam int cycles_per_tx = 12;

  logic      clk;
  logic      arst_n;
  logic      req;
  div_req_t  req_data;
  logic      ack;
  div_resp_t resp;

  // Test table as read from the stimulus file
  string      test_name   [max_tests];
  dividend_t  test_n      [max_tests];
  divisor_t   test_d      [max_tests];
  logic       test_approx [max_tests];
  quot_t      exp_q       [max_tests];
  rem_t       exp_r       [max_tests];
  logic [1:0] exp_status  [max_tests];
  int         n_tests;
  logic       loaded;
  int         seed;

  approx_div_unit i_approx_div_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .resp     (resp)
  );

  always #5 clk = ~clk;

  task automatic check_flag(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic compare_value(input string test, input string field, input int expected,
                               input int actual);
    assert (actual == expected) else begin
      $display("Error in test %s (%s): expected %0h, actual %0h", test, field, expected,
               actual);
      $display("Errors found");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic load_stimulus();
    int         fd;
    int         cnt;
    string      line;
    string      name;
    dividend_t  n;
    divisor_t   d;
    logic       a;
    quot_t      q;
    rem_t       r;
    logic [1:0] s;
    fd = $fopen("dv/approx_div_stimulus.txt", "r");
    check_flag(fd != 0, "Could not open the stimulus file dv/approx_div_stimulus.txt");
    n_tests = 0;
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (line.len() < 2 || line.substr(0, 1) == "//") continue;  // Blank or comment
      cnt = $sscanf(line, "%s %h %h %h %h %h %h", name, n, d, a, q, r, s);
      check_flag(cnt == 7, "Malformed line in the stimulus file");
      check_flag(n_tests < max_tests, "Too many tests in the stimulus file");
      test_name[n_tests]   = name;
      test_n[n_tests]      = n;
      test_d[n_tests]      = d;
      test_approx[n_tests] = a;
      exp_q[n_tests]       = q;
      exp_r[n_tests]       = r;
      exp_status[n_tests]  = s;
      n_tests++;
    end
    $fclose(fd);
    check_flag(n_tests > 0, "The stimulus file holds no tests");
  endtask

  // One four-phase transaction with req held for hold extra cycles after ack
  task automatic run_transaction(input int idx, input int hold);
    int        edges;
    div_resp_t held;
    req_data.dividend = test_n[idx];
    req_data.divisor  = test_d[idx];
    req_data.approx   = test_approx[idx];
    req               = 1'b1;
    edges = 0;
    while (!ack) begin
      @(posedge clk);
      #1;
      edges++;
    end
    compare_value(test_name[idx], "ack latency in edges", 4, edges);
    compare_value(test_name[idx], "quotient", int'(exp_q[idx]), int'(resp.q));
    compare_value(test_name[idx], "remainder", int'(exp_r[idx]), int'(resp.r));
    compare_value(test_name[idx], "status", int'(exp_status[idx]), int'(resp.status));
    held = resp;
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_flag(ack, "ack dropped while req was still high");
      check_flag(resp == held, "resp changed while ack was high");
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    check_flag(!ack, "ack did not fall on the edge that sampled req low");
  endtask

  initial begin : main_seq
    int gap;
    int hold;
    clk      = 1'b0;
    arst_n   = 1'b0;
    req      = 1'b0;
    req_data = '0;
    loaded   = 1'b0;
    seed     = 4871;
    load_stimulus();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (4) begin  // Nothing answers before the first request
      @(posedge clk);
      #1;
      check_flag(!ack, "ack rose before any request was made");
    end
    for (int i = 0; i < n_tests; i++) begin
      run_transaction(i, 0);  // Back to back
    end
    // Random idle gaps and late release of req
    for (int i = 0; i < n_tests; i++) begin
      gap  = $random(seed) & 3;
      hold = $random(seed) & 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      run_transaction(i, hold);
    end
    $display("No errors");
    $finish;
  end

  // Two passes over the table plus reset and the idle check
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = reset_cycles + 4 + 2 * n_tests * cycles_per_tx;
    repeat (limit) @(posedge clk);
    $display("Timeout: the req/ack handshake hung, no completion within %0d cycles", limit);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: dv/approx_div_stimulus.txt
// name dividend divisor approx exp_quotient exp_remainder exp_status (hex)
// status: 0 ok, 1 divide by zero, 2 overflow
exact_basic       0064 07 0 0e 02 0
approx_basic      0064 07 1 00 64 0
exact_mixed       1234 c8 0 17 3c 0
approx_mixed      1234 c8 1 1f 34 0
exact_div_one     00ff 01 0 ff 00 0
approx_div_one    00ff 01 1 f0 0f 0
exact_mid         3a5c 5b 0 a4 10 0
approx_mid        3a5c 5b 1 a1 6f 0
exact_all_ones    7f00 ff 0 7f 7f 0
approx_all_ones   7f00 ff 1 7f 75 0
exact_small       0003 05 0 00 03 0
approx_small      0003 05 1 00 03 0
exact_zero_n      0000 2a 0 00 00 0
approx_zero_n     0000 2a 1 00 00 0
exact_max         feff ff 0 ff fe 0
div_zero_exact    1234 00 0 ff 34 1
div_zero_approx   abcd 00 1 ff cd 1
overflow_equal    0500 05 0 ff ff 2
overflow_greater  ff00 10 1 ff ff 2
overflow_top      8000 01 0 ff ff 2

// File: approx_div_unit.f
+incdir+logic
logic/div_pkg.sv
logic/div_cell.sv
logic/div_array.sv
logic/div_decode.sv
logic/div_execute.sv
logic/div_result.sv
logic/approx_div_unit.sv
dv/approx_div_unit_asserts.sv
dv/approx_div_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module approx_div_unit_tb -f approx_div_unit.f \
  -Mdir obj_dir -o approx_div_sim \
  && ./obj_dir/approx_div_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: simulation did not complete"; exit 1; }
echo "PASS"
